//--- hdl/me_config.svh
/*
 * Build-time constants for the modular exponentiation core.
 * Include wherever the operand width, the modulus or rho is needed.
 */

`ifndef ME_CONFIG_SVH
`define ME_CONFIG_SVH

// operand width, R = 2^ME_WIDTH
`define ME_WIDTH 32

// odd prime modulus, R mod m = 5
`define ME_MODULUS 32'hfffffffb

// R^2 mod m
`define ME_RHO 32'd25

`endif

//--- hdl/me_ctrl.sv
/*
 * Controller for x^y mod m, left-to-right square-and-multiply.
 * Sequences the Montgomery steps, walks the exponent MSB first and
 * produces the busy level and the done pulse.
 */

`timescale 1ns/1ps
`include "me_config.svh"

module me_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  me_pkg::operand_t  y,
    input  logic              mul_done,
    output logic              mul_start,
    output logic              done,
    output logic              busy,
    output me_pkg::me_state_t state
);

    localparam me_pkg::bit_cnt_t LAST_BIT = me_pkg::bit_cnt_t'(`ME_WIDTH - 1);

    me_pkg::me_state_t state_next;
    me_pkg::operand_t  exp_q;
    me_pkg::bit_cnt_t  bit_cnt;
    logic              exp_msb;
    logic              last_bit;
    logic              bit_done;
    logic              launch;

    assign exp_msb  = exp_q[`ME_WIDTH-1];
    assign last_bit = (bit_cnt == LAST_BIT);

    // current exponent bit is finished
    assign bit_done = mul_done &&
                      ((state == me_pkg::ST_SQUARE && !exp_msb) ||
                       state == me_pkg::ST_MULTIPLY);

    // every state entry, square re-entry included, starts one multiply
    assign launch = (state == me_pkg::ST_IDLE) ? start
                                               : (mul_done && state != me_pkg::ST_FINAL);

    assign busy = (state != me_pkg::ST_IDLE);

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_next = state;
        case (state)
            me_pkg::ST_IDLE: begin
                if (start) begin
                    state_next = me_pkg::ST_INIT_R;
                end
            end
            me_pkg::ST_INIT_R: begin
                if (mul_done) begin
                    state_next = me_pkg::ST_TO_MONT;
                end
            end
            me_pkg::ST_TO_MONT: begin
                if (mul_done) begin
                    state_next = me_pkg::ST_SQUARE;
                end
            end
            me_pkg::ST_SQUARE: begin
                if (mul_done) begin
                    if (exp_msb) begin
                        state_next = me_pkg::ST_MULTIPLY;
                    end else if (last_bit) begin
                        state_next = me_pkg::ST_FINAL;
                    end
                end
            end
            me_pkg::ST_MULTIPLY: begin
                if (mul_done) begin
                    state_next = last_bit ? me_pkg::ST_FINAL : me_pkg::ST_SQUARE;
                end
            end
            me_pkg::ST_FINAL: begin
                if (mul_done) begin
                    state_next = me_pkg::ST_IDLE;
                end
            end
            default: begin
                state_next = me_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= me_pkg::ST_IDLE;
            bit_cnt   <= '0;
            mul_start <= 1'b0;
            done      <= 1'b0;
        end else begin
            state     <= state_next;
            mul_start <= launch;
            done      <= mul_done && state == me_pkg::ST_FINAL;
            if (state == me_pkg::ST_IDLE) begin
                bit_cnt <= '0;
            end else if (bit_done) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // exponent shifts left, msb is the bit in work
    always_ff @(posedge clk) begin
        if (state == me_pkg::ST_IDLE && start) begin
            exp_q <= y;
        end else if (bit_done) begin
            exp_q <= exp_q << 1;
        end
    end

endmodule

//--- hdl/me_operand_regs.sv
/*
 * Working registers of the exponentiation and the multiplier operand mux.
 * result2 holds x in Montgomery form, result_q the running value, and
 * result the last finished answer.
 */

`timescale 1ns/1ps
`include "me_config.svh"

module me_operand_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  me_pkg::operand_t  x,
    input  me_pkg::me_state_t state,
    input  logic              mul_done,
    input  me_pkg::operand_t  mul_res,
    output me_pkg::operand_t  a,
    output me_pkg::operand_t  b,
    output me_pkg::operand_t  result
);

    localparam me_pkg::operand_t RHO = `ME_RHO;
    localparam me_pkg::operand_t ONE = me_pkg::operand_t'(1);

    me_pkg::operand_t x_q;
    me_pkg::operand_t result2_q;
    me_pkg::operand_t result_q;

    always_ff @(posedge clk) begin
        if (start && state == me_pkg::ST_IDLE) begin
            x_q <= x;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_done) begin
            if (state == me_pkg::ST_TO_MONT) begin
                result2_q <= mul_res;
            end else begin
                result_q <= mul_res;
            end
        end
    end

    // only the final conversion reaches the output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (mul_done && state == me_pkg::ST_FINAL) begin
            result <= mul_res;
        end
    end

    // --------------------
    // operand select
    // --------------------
    always_comb begin
        a = result_q;
        b = ONE;
        case (state)
            me_pkg::ST_INIT_R: begin
                a = RHO;
                b = ONE;
            end
            me_pkg::ST_TO_MONT: begin
                a = x_q;
                b = RHO;
            end
            me_pkg::ST_SQUARE: begin
                b = result_q;
            end
            me_pkg::ST_MULTIPLY: begin
                b = result2_q;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hdl/me_pkg.sv
/*
 * Shared types for the modular exponentiation core.
 * Referenced through scoped names only.
 */

package me_pkg;

    `include "me_config.svh"

    // operand, residue or result
    typedef logic [`ME_WIDTH-1:0] operand_t;

    // montgomery accumulator, two guard bits
    typedef logic [`ME_WIDTH+1:0] acc_t;

    // exponent bits or multiplier iterations
    typedef logic [$clog2(`ME_WIDTH):0] bit_cnt_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INIT_R,
        ST_TO_MONT,
        ST_SQUARE,
        ST_MULTIPLY,
        ST_FINAL
    } me_state_t;

endpackage

//--- hdl/me_top.sv
/*
 * Modular exponentiation top, result = x^y mod m.
 * Pulse start with x and y while busy is low; done marks the result.
 */

`timescale 1ns/1ps

module me_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  me_pkg::operand_t x,
    input  me_pkg::operand_t y,
    output me_pkg::operand_t result,
    output logic             done,
    output logic             busy
);

    logic              mul_start;
    logic              mul_done;
    me_pkg::me_state_t state;
    me_pkg::operand_t  mul_a;
    me_pkg::operand_t  mul_b;
    me_pkg::operand_t  mul_res;

    me_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .y         (y),
        .mul_done  (mul_done),
        .mul_start (mul_start),
        .done      (done),
        .busy      (busy),
        .state     (state)
    );

    me_operand_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .x        (x),
        .state    (state),
        .mul_done (mul_done),
        .mul_res  (mul_res),
        .a        (mul_a),
        .b        (mul_b),
        .result   (result)
    );

    mont_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mul_start),
        .a     (mul_a),
        .b     (mul_b),
        .done  (mul_done),
        .res   (mul_res)
    );

endmodule

//--- hdl/mont_mul.sv
/*
 * Bit-serial radix-2 Montgomery multiplier, res = a*b*R^-1 mod m.
 * A start pulse while idle latches a and b; done pulses with res valid
 * ME_WIDTH+1 cycles later. b must be below m.
 */

`timescale 1ns/1ps
`include "me_config.svh"

module mont_mul (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  me_pkg::operand_t a,
    input  me_pkg::operand_t b,
    output logic             done,
    output me_pkg::operand_t res
);

    localparam me_pkg::operand_t MODULUS   = `ME_MODULUS;
    localparam me_pkg::bit_cnt_t LAST_ITER = me_pkg::bit_cnt_t'(`ME_WIDTH - 1);

    logic             busy_q;
    me_pkg::bit_cnt_t iter_cnt;
    me_pkg::operand_t a_q;
    me_pkg::operand_t b_q;
    me_pkg::acc_t     acc_q;
    me_pkg::acc_t     acc_add;
    me_pkg::acc_t     acc_sum;
    me_pkg::acc_t     acc_sub;

    // --------------------
    // one iteration
    // --------------------
    always_comb begin
        acc_add = acc_q + (a_q[0] ? me_pkg::acc_t'(b_q) : '0);
        // make it even so the halving is exact
        acc_sum = acc_add + (acc_add[0] ? me_pkg::acc_t'(MODULUS) : '0);
    end

    // acc stays below 2m, one subtraction is enough
    assign acc_sub = acc_q - me_pkg::acc_t'(MODULUS);
    assign res     = (acc_q >= me_pkg::acc_t'(MODULUS)) ? acc_sub[`ME_WIDTH-1:0]
                                                        : acc_q[`ME_WIDTH-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            iter_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy_q) begin
                busy_q   <= 1'b1;
                iter_cnt <= '0;
            end else if (busy_q) begin
                iter_cnt <= iter_cnt + 1'b1;
                if (iter_cnt == LAST_ITER) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy_q) begin
            a_q   <= a;
            b_q   <= b;
            acc_q <= '0;
        end else if (busy_q) begin
            // lsb first through a
            a_q   <= a_q >> 1;
            acc_q <= acc_sum >> 1;
        end
    end

endmodule

//--- project.f
+incdir+hdl
hdl/me_pkg.sv
hdl/mont_mul.sv
hdl/me_operand_regs.sv
hdl/me_ctrl.sv
hdl/me_top.sv
verif/me_props.sv
verif/me_tb.sv

//--- verif/me_props.sv
/*
 * Concurrent assertions on the modular exponentiation top.
 * Attached to me_top by the bind at the end of this file.
 */

`timescale 1ns/1ps
`include "me_config.svh"

module me_props (
    input logic             clk,
    input logic             rst_n,
    input logic             done,
    input logic             busy,
    input logic             mul_start,
    input logic             mul_done,
    input me_pkg::operand_t result
);

    localparam me_pkg::acc_t MODULUS = me_pkg::acc_t'(`ME_MODULUS);

    logic mul_active;

    // multiplication in flight from start pulse to done pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_active <= 1'b0;
        end else if (mul_start) begin
            mul_active <= 1'b1;
        end else if (mul_done) begin
            mul_active <= 1'b0;
        end
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done lasted longer than one cycle");

    busy_low_in_reset: assert property (@(posedge clk) !rst_n |-> !busy)
        else $error("busy high during reset");

    mul_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |-> !mul_active)
        else $error("multiplier started while still running");

    result_below_modulus: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> me_pkg::acc_t'(result) < MODULUS)
        else $error("result not reduced below the modulus");

    result_held: assert property (@(posedge clk) disable iff (!rst_n)
        !done |-> $stable(result))
        else $error("result changed outside a done pulse");

endmodule

bind me_top me_props props0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .done      (done),
    .busy      (busy),
    .mul_start (mul_start),
    .mul_done  (mul_done),
    .result    (result)
);

//--- verif/me_tb.sv
/*
 * Testbench for me_top covering reset values, exponent edge cases, random
 * operands, a start while busy and back-to-back runs against a reference model.
 */

`timescale 1ns/1ps
`include "me_config.svh"

module me_tb;

    localparam me_pkg::operand_t MODULUS = `ME_MODULUS;
    localparam logic [63:0] MOD64 = {32'd0, MODULUS};
    localparam int TIMEOUT_CYCLES = 4000;

    logic             clk;
    logic             rst_n;
    logic             start;
    me_pkg::operand_t x;
    me_pkg::operand_t y;
    me_pkg::operand_t result;
    logic             done;
    logic             busy;

    me_pkg::operand_t expected_q[$];
    me_pkg::operand_t lcg_state;
    int               ops_issued;
    int               done_count;

    me_top dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .x      (x),
        .y      (y),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // --------------------
    // model and helpers
    // --------------------
    function automatic me_pkg::operand_t rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // plain square-and-multiply from the msb down
    function automatic me_pkg::operand_t ref_modexp(input me_pkg::operand_t base,
                                                   input me_pkg::operand_t exponent);
        logic [63:0] acc;
        logic [63:0] b64;
        acc = 64'd1;
        b64 = {32'd0, base} % MOD64;
        for (int i = `ME_WIDTH - 1; i >= 0; i--) begin
            acc = (acc * acc) % MOD64;
            if (exponent[i]) begin
                acc = (acc * b64) % MOD64;
            end
        end
        return acc[31:0];
    endfunction

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compare_operand(input me_pkg::operand_t actual,
                                   input me_pkg::operand_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic compare_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic issue_op(input me_pkg::operand_t x_val, input me_pkg::operand_t y_val,
                            input me_pkg::operand_t expected);
        @(posedge clk);
        start <= 1'b1;
        x     <= x_val;
        y     <= y_val;
        expected_q.push_back(expected);
        ops_issued++;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("Timed out after %0d cycles waiting for done", TIMEOUT_CYCLES);
                stop_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_for_busy();
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy !== 1'b1) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("Timed out waiting for busy to rise after start");
                stop_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic run_op(input me_pkg::operand_t x_val, input me_pkg::operand_t y_val,
                          input me_pkg::operand_t expected);
        issue_op(x_val, y_val, expected);
        wait_for_done();
    endtask

    // --------------------
    // checker
    // --------------------
    initial begin : check_results
        me_pkg::operand_t held;
        me_pkg::operand_t exp_val;
        logic             busy_prev;
        int               waited;
        held      = '0;
        busy_prev = 1'b0;
        waited    = 0;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && done === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("done pulsed with no operation pending");
                    stop_run();
                end else begin
                    exp_val = expected_q.pop_front();
                    compare_operand(result, exp_val, "result");
                    compare_bit(busy, 1'b0, "busy in the done cycle");
                    compare_bit(busy_prev, 1'b1, "busy before the done cycle");
                    held = result;
                    waited = 0;
                    done_count++;
                end
            end else if (rst_n === 1'b1) begin
                compare_operand(result, held, "result between done pulses");
                // only count while an operation is outstanding
                waited = (expected_q.size() != 0) ? waited + 1 : 0;
                if (waited > TIMEOUT_CYCLES) begin
                    $display("Timed out after %0d cycles waiting for done", TIMEOUT_CYCLES);
                    stop_run();
                end
            end
            busy_prev = busy;
        end
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin : stimulus
        me_pkg::operand_t xa;
        me_pkg::operand_t ya;
        int               dones_before;
        rst_n      = 1'b0;
        start      = 1'b0;
        x          = '0;
        y          = '0;
        lcg_state  = 32'hb5b9;
        ops_issued = 0;
        done_count = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        compare_bit(busy, 1'b0, "busy after reset");
        compare_bit(done, 1'b0, "done after reset");
        compare_operand(result, '0, "result after reset");

        // expected values straight from the exponent rules
        run_op(32'h0000_1234, 32'd0, 32'd1);
        run_op(MODULUS - 1, 32'd0, 32'd1);
        run_op(32'hdead_beef, 32'd1, 32'hdead_beef);
        run_op(32'd0, 32'd5, 32'd0);
        run_op(32'd0, 32'hffff_ffff, 32'd0);
        run_op(MODULUS - 1, 32'd2, 32'd1);

        repeat (20) begin
            xa = rand_word() % MODULUS;
            ya = rand_word();
            run_op(xa, ya, ref_modexp(xa, ya));
        end

        // second start lands mid-operation and must be dropped
        xa = rand_word() % MODULUS;
        ya = rand_word();
        issue_op(xa, ya, ref_modexp(xa, ya));
        dones_before = done_count;
        wait_for_busy();
        repeat (40) @(posedge clk);
        start <= 1'b1;
        x     <= rand_word() % MODULUS;
        y     <= rand_word();
        @(posedge clk);
        start <= 1'b0;
        wait_for_done();
        repeat (200) begin
            @(negedge clk);
            compare_bit(busy, 1'b0, "busy after the ignored start");
        end
        if (done_count != dones_before + 1) begin
            $display("A start while busy produced an extra done pulse");
            stop_run();
        end

        // next start right after each done
        repeat (4) begin
            xa = rand_word() % MODULUS;
            ya = rand_word();
            run_op(xa, ya, ref_modexp(xa, ya));
        end

        repeat (4) @(negedge clk);
        if (done_count == ops_issued && expected_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Number of done pulses does not match the operations started");
            stop_run();
        end
    end

endmodule
